// ==== vlog.f ====
src/ldr_pkg.sv
src/local_bank.sv
src/wb_ldr_regs.sv
src/cmd_gen.sv
src/sram_write_collector.sv
src/ldr_top.sv
tests/tb_ldr.sv

// ==== run.sh ====
#!/bin/sh
# Build the tile loader testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_ldr \
	-f vlog.f -o sim_ldr || exit 1
result=$(./obj_dir/sim_ldr)
echo "$result"
echo "$result" | grep -qx "Done: no errors" && echo "PASS" || {
	echo "FAIL"
	exit 1
}

// ==== tests/tb_ldr.sv ====
`timescale 1ns/1ps
// Tile loader testbench
// Random block descriptors and DRAM beats from an LFSR, bank contents and
// beat acks checked against a model with ping-pong row pointers

module tb_ldr;
	import ldr_pkg::*;

	localparam logic [15:0] SEED = 16'd55033;
	localparam int NBEAT    = 20;
	localparam int WB_TMO   = 20;
	localparam int POLL_TMO = 400;
	localparam int RDY_SPARSE = 0;
	localparam int RDY_LOW    = 1;
	localparam int RDY_HIGH   = 2;
	localparam int RDY_HALF   = 3;

	logic                      i_clk;
	logic                      i_rst;
	logic                      i_wb_cyc;
	logic                      i_wb_stb;
	logic                      i_wb_we;
	logic [WB_AW-1:0]          i_wb_adr;
	logic [DBW-1:0]            i_wb_dat;
	logic [DBW-1:0]            o_wb_dat;
	logic                      o_wb_ack;
	logic                      i_dram_rdy;
	logic                      o_dram_ack;
	logic [CSIZE-1:0][DBW-1:0] i_dram_data;

	logic [15:0]               lfsr;
	logic [15:0]               lfsr_rdy;
	logic [CSIZE-1:0][DBW-1:0] beats [NBEAT];
	logic [DBW-1:0]            mdl [2][ROWS][VSIZE];
	int                        mptr [2];
	int                        rdy_mode;
	int                        dram_acks;
	int                        blk_bank;
	int                        blk_first;
	int                        blk_rows;
	int                        blk_need;
	int                        checks;
	int                        errors;
	int                        test_err0;
	string                     test_name;

	ldr_top #(.VSIZE(VSIZE), .CSIZE(CSIZE), .ROWS(ROWS)) uut (.*);

	always #10 i_clk = ~i_clk;

	// ============================================================
	// Random source, checks and run control
	// ============================================================
	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(inout logic [15:0] st, input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			st = lfsr_next(st);
			v = {v[30:0], st[0]};
		end
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic abort_run(input string what);
		$display("%0t ns run aborted: %s", $time, what);
		$display("Done: errors found");
		$finish;
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_err0 = errors;
	endtask

	task automatic end_test();
		if (errors == test_err0) begin
			$display("test %s: passed", test_name);
		end else begin
			$display("test %s: %0d errors", test_name, errors - test_err0);
		end
	endtask

	// ============================================================
	// DRAM beat source
	// ============================================================
	// Beat index follows the acks, rdy pattern follows rdy_mode
	always begin
		logic [31:0] r;
		logic        acked;
		int          mode_s;
		@(negedge i_clk);
		acked  = o_dram_ack;
		@(posedge i_clk);
		#1;
		mode_s = rdy_mode;
		if (acked) begin
			dram_acks = dram_acks + 1;
		end
		i_dram_data = beats[dram_acks < NBEAT ? dram_acks : NBEAT - 1];
		take_bits(lfsr_rdy, 3, r);
		case (mode_s)
			RDY_SPARSE: i_dram_rdy = &r[2:0];
			RDY_LOW:    i_dram_rdy = 1'b0;
			RDY_HIGH:   i_dram_rdy = 1'b1;
			default:    i_dram_rdy = r[0];
		endcase
	end

	// ============================================================
	// Wishbone host
	// ============================================================
	task automatic wb_access(input logic we, input logic [WB_AW-1:0] adr,
			input logic [DBW-1:0] wdat, output logic [DBW-1:0] rdat);
		int n;
		@(posedge i_clk);
		#1;
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		i_wb_we  = we;
		i_wb_adr = adr;
		i_wb_dat = wdat;
		n = 0;
		do begin
			@(negedge i_clk);
			n++;
		end while (!o_wb_ack && n < WB_TMO);
		if (!o_wb_ack) begin
			abort_run("Wishbone access got no ack");
		end else begin
			// Ack is due on the cycle after the request
			compare_value("o_wb_ack delay", 32'(n), 32'd2);
			rdat = o_wb_dat;
			@(posedge i_clk);
			#1;
			i_wb_cyc = 1'b0;
			i_wb_stb = 1'b0;
			i_wb_we  = 1'b0;
			@(negedge i_clk);
			compare_value("o_wb_ack pulse end", 32'(o_wb_ack), 32'd0);
		end
	endtask

	task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [DBW-1:0] dat);
		logic [DBW-1:0] unused;
		wb_access(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [DBW-1:0] dat);
		wb_access(1'b0, adr, '0, dat);
	endtask

	function automatic logic [WB_AW-1:0] bank_adr(input int b, input int row, input int w);
		return WB_AW'((1 << 8) | (b << 7) | (row << 3) | w);
	endfunction

	function automatic ldr_desc_t make_desc(input int size, input fill_mode_e mode,
			input int ofs, input logic [DBW-1:0] padv, input logic which, input logic last);
		ldr_desc_t d;
		d.size      = SZ_BW'(size);
		d.mode      = mode;
		d.ofs       = OFS_BW'(ofs);
		d.padv      = padv;
		d.which     = which;
		d.islast_id = last;
		return d;
	endfunction

	task automatic rand_desc(output ldr_desc_t d);
		logic [31:0] r;
		d = '0;
		take_bits(lfsr, 5, r);
		d.size = SZ_BW'(r % 24 + 1);
		take_bits(lfsr, 2, r);
		d.mode = (r == 3) ? FILL_COPY : fill_mode_e'(r[1:0]);
		take_bits(lfsr, OFS_BW, r);
		d.ofs = OFS_BW'(r);
		take_bits(lfsr, DBW, r);
		d.padv = r[DBW-1:0];
		take_bits(lfsr, 2, r);
		d.which     = r[0];
		d.islast_id = r[1];
	endtask

	task automatic write_desc(input ldr_desc_t d);
		wb_write(WB_AW'(0), DBW'(d.size));
		wb_write(WB_AW'(1), DBW'({d.islast_id, d.which, d.mode}));
		wb_write(WB_AW'(2), DBW'(d.ofs));
		wb_write(WB_AW'(3), d.padv);
	endtask

	// ============================================================
	// Bank model
	// ============================================================
	task automatic model_block(input ldr_desc_t d);
		int             b;
		int             pos;
		int             last_row;
		logic [DBW-1:0] v;
		b         = int'(d.which);
		blk_bank  = b;
		blk_first = mptr[b];
		blk_rows  = (int'(d.size) + VSIZE - 1) / VSIZE;
		for (int j = 0; j < int'(d.size); j++) begin
			pos = int'(d.ofs) + j;
			case (d.mode)
				FILL_COPY:  v = beats[pos / CSIZE][pos % CSIZE];
				FILL_BCAST: v = beats[0][d.ofs];
				default:    v = d.padv;
			endcase
			mdl[b][(blk_first + j / VSIZE) % ROWS][j % VSIZE] = v;
		end
		case (d.mode)
			FILL_COPY:  blk_need = (int'(d.ofs) + int'(d.size) + CSIZE - 1) / CSIZE;
			FILL_BCAST: blk_need = 1;
			default:    blk_need = 0;
		endcase
		last_row = (blk_first + blk_rows - 1) % ROWS;
		if (d.islast_id) begin
			// Next group starts in the half opposite the last row written
			mptr[b] = (last_row < ROWS / 2) ? ROWS / 2 : 0;
		end else begin
			mptr[b] = (blk_first + blk_rows) % ROWS;
		end
	endtask

	task automatic start_block(input ldr_desc_t d, input int rmode);
		logic [31:0] r;
		for (int k = 0; k < NBEAT; k++) begin
			for (int w = 0; w < CSIZE; w++) begin
				take_bits(lfsr, DBW, r);
				beats[k][w] = r[DBW-1:0];
			end
		end
		rdy_mode  = rmode;
		dram_acks = 0;
		write_desc(d);
		model_block(d);
		wb_write(WB_AW'(4), DBW'(1));
	endtask

	task automatic wait_idle();
		logic [DBW-1:0] rd;
		int             n;
		n = 0;
		do begin
			wb_read(WB_AW'(4), rd);
			n++;
		end while (rd[0] && n < POLL_TMO);
		if (rd[0]) begin
			abort_run("block never finished, busy stayed high");
		end
	endtask

	task automatic check_rows(input int b, input int first, input int nrows);
		logic [DBW-1:0] rd;
		int             row;
		for (int i = 0; i < nrows; i++) begin
			row = (first + i) % ROWS;
			for (int w = 0; w < VSIZE; w++) begin
				wb_read(bank_adr(b, row, w), rd);
				compare_value($sformatf("bank%0d[%0d][%0d]", b, row, w),
					32'(rd), 32'(mdl[b][row][w]));
			end
		end
	endtask

	task automatic finish_block();
		wait_idle();
		compare_value("dram acks", 32'(dram_acks), 32'(blk_need));
		check_rows(blk_bank, blk_first, blk_rows);
	endtask

	// ============================================================
	// Test sequence
	// ============================================================
	initial begin
		ldr_desc_t      d;
		logic [DBW-1:0] rd;
		logic [31:0]    r;
		i_clk       = 1'b0;
		i_rst       = 1'b0;
		i_wb_cyc    = 1'b0;
		i_wb_stb    = 1'b0;
		i_wb_we     = 1'b0;
		i_wb_adr    = '0;
		i_wb_dat    = '0;
		i_dram_rdy  = 1'b0;
		i_dram_data = '0;
		lfsr        = SEED;
		lfsr_rdy    = SEED;
		rdy_mode    = RDY_LOW;
		dram_acks   = 0;
		checks      = 0;
		errors      = 0;
		mptr[0]     = 0;
		mptr[1]     = 0;
		for (int k = 0; k < NBEAT; k++) begin
			beats[k] = '0;
		end
		repeat (8) @(posedge i_clk);
		#1;
		i_rst = 1'b1;

		begin_test("reset");
		wb_read(WB_AW'(4), rd);
		compare_value("busy", 32'(rd), 32'd0);
		end_test();

		// Whole banks get known contents, pointers wrap back to row 0
		begin_test("prefill");
		start_block(make_desc(ROWS * VSIZE, FILL_COPY, 0, '0, 1'b0, 1'b0), RDY_HIGH);
		finish_block();
		start_block(make_desc(ROWS * VSIZE, FILL_COPY, 0, '0, 1'b1, 1'b0), RDY_HIGH);
		finish_block();
		end_test();

		begin_test("copy_offset");
		start_block(make_desc(10, FILL_COPY, 3, '0, 1'b0, 1'b0), RDY_HIGH);
		finish_block();
		end_test();

		begin_test("bcast_pad");
		start_block(make_desc(7, FILL_BCAST, 2, '0, 1'b1, 1'b0), RDY_HALF);
		finish_block();
		start_block(make_desc(9, FILL_PAD, 0, 16'h5a3c, 1'b1, 1'b0), RDY_LOW);
		finish_block();
		end_test();

		begin_test("pingpong");
		start_block(make_desc(5, FILL_COPY, 1, '0, 1'b0, 1'b1), RDY_HALF);
		finish_block();
		start_block(make_desc(8, FILL_PAD, 0, 16'h0f0f, 1'b0, 1'b1), RDY_LOW);
		finish_block();
		start_block(make_desc(6, FILL_BCAST, 3, '0, 1'b0, 1'b0), RDY_HALF);
		finish_block();
		end_test();

		// DRAM held off so the block stays busy through the second start
		begin_test("start_while_busy");
		start_block(make_desc(20, FILL_COPY, 1, '0, 1'b1, 1'b0), RDY_LOW);
		write_desc(make_desc(5, FILL_PAD, 0, 16'h1234, 1'b0, 1'b1));
		wb_write(WB_AW'(4), DBW'(1));
		wb_read(WB_AW'(4), rd);
		compare_value("busy", 32'(rd), 32'd1);
		wb_read(WB_AW'(0), rd);
		compare_value("desc size", 32'(rd), 32'd20);
		rdy_mode = RDY_SPARSE;
		finish_block();
		wb_read(WB_AW'(4), rd);
		compare_value("busy", 32'(rd), 32'd0);
		end_test();

		begin_test("random");
		for (int i = 0; i < 40; i++) begin
			rand_desc(d);
			take_bits(lfsr, 1, r);
			if (d.mode == FILL_PAD) begin
				start_block(d, RDY_LOW);
			end else begin
				start_block(d, r[0] ? RDY_SPARSE : RDY_HALF);
			end
			finish_block();
		end
		end_test();

		begin_test("final_banks");
		check_rows(0, 0, ROWS);
		check_rows(1, 0, ROWS);
		end_test();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== src/ldr_top.sv ====
`timescale 1ns/1ps
// Tile loader top level
// Host registers, command generator, write collector and two local banks

module ldr_top #(
	parameter int VSIZE = ldr_pkg::VSIZE,
	parameter int CSIZE = ldr_pkg::CSIZE,
	parameter int ROWS  = ldr_pkg::ROWS
) (
	input  logic                               i_clk,
	input  logic                               i_rst,
	input  logic                               i_wb_cyc,
	input  logic                               i_wb_stb,
	input  logic                               i_wb_we,
	input  logic [ldr_pkg::WB_AW-1:0]          i_wb_adr,
	input  logic [ldr_pkg::DBW-1:0]            i_wb_dat,
	output logic [ldr_pkg::DBW-1:0]            o_wb_dat,
	output logic                               o_wb_ack,
	input  logic                               i_dram_rdy,
	output logic                               o_dram_ack,
	input  logic [CSIZE-1:0][ldr_pkg::DBW-1:0] i_dram_data
);
	import ldr_pkg::*;

	ldr_desc_t                desc;
	ldr_desc_t                alloc;
	ldr_cmd_t                 cmd;
	row_wr_t                  wr0;
	row_wr_t                  wr1;
	logic                     start;
	logic                     done;
	logic                     alloc_rdy;
	logic                     alloc_ack;
	logic                     cmd_rdy;
	logic                     cmd_ack;
	logic                     wr0_valid;
	logic                     wr1_valid;
	logic                     rd_bank;
	logic [$clog2(ROWS)-1:0]  rd_row;
	logic [$clog2(VSIZE)-1:0] rd_word;
	logic [DBW-1:0]           rd_data0;
	logic [DBW-1:0]           rd_data1;
	logic [DBW-1:0]           rd_data;

	assign rd_data = rd_bank ? rd_data1 : rd_data0;

	wb_ldr_regs #(.VSIZE(VSIZE), .ROWS(ROWS)) u_regs (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
		.i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat),
		.o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack),
		.o_desc(desc), .o_start(start), .i_done(done),
		.o_rd_bank(rd_bank), .o_rd_row(rd_row), .o_rd_word(rd_word),
		.i_rd_data(rd_data)
	);

	cmd_gen #(.VSIZE(VSIZE), .CSIZE(CSIZE)) u_cmd_gen (
		.i_clk(i_clk), .i_rst(i_rst), .i_desc(desc), .i_start(start),
		.o_alloc_rdy(alloc_rdy), .i_alloc_ack(alloc_ack), .o_alloc(alloc),
		.o_cmd_rdy(cmd_rdy), .i_cmd_ack(cmd_ack), .o_cmd(cmd)
	);

	sram_write_collector #(.VSIZE(VSIZE), .CSIZE(CSIZE), .ROWS(ROWS)) u_collector (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_alloc_rdy(alloc_rdy), .o_alloc_ack(alloc_ack), .i_alloc(alloc),
		.i_cmd_rdy(cmd_rdy), .o_cmd_ack(cmd_ack), .i_cmd(cmd),
		.i_dram_rdy(i_dram_rdy), .o_dram_ack(o_dram_ack), .i_dram_data(i_dram_data),
		.o_wr0_valid(wr0_valid), .o_wr0(wr0),
		.o_wr1_valid(wr1_valid), .o_wr1(wr1),
		.o_done(done)
	);

	local_bank #(.VSIZE(VSIZE), .ROWS(ROWS)) u_bank0 (
		.i_clk(i_clk), .i_rst(i_rst), .i_wr_valid(wr0_valid), .i_wr(wr0),
		.i_rd_row(rd_row), .i_rd_word(rd_word), .o_rd_data(rd_data0)
	);

	local_bank #(.VSIZE(VSIZE), .ROWS(ROWS)) u_bank1 (
		.i_clk(i_clk), .i_rst(i_rst), .i_wr_valid(wr1_valid), .i_wr(wr1),
		.i_rd_row(rd_row), .i_rd_word(rd_word), .o_rd_data(rd_data1)
	);

endmodule

// ==== src/sram_write_collector.sv ====
`timescale 1ns/1ps
// SRAM write collector
// Packs DRAM beat words into local rows under command control, writes
// each finished row to its bank and keeps ping-pong row pointers

module sram_write_collector #(
	parameter int VSIZE = ldr_pkg::VSIZE,
	parameter int CSIZE = ldr_pkg::CSIZE,
	parameter int ROWS  = ldr_pkg::ROWS
) (
	input  logic                               i_clk,
	input  logic                               i_rst,
	input  logic                               i_alloc_rdy,
	output logic                               o_alloc_ack,
	input  ldr_pkg::ldr_desc_t                 i_alloc,
	input  logic                               i_cmd_rdy,
	output logic                               o_cmd_ack,
	input  ldr_pkg::ldr_cmd_t                  i_cmd,
	input  logic                               i_dram_rdy,
	output logic                               o_dram_ack,
	input  logic [CSIZE-1:0][ldr_pkg::DBW-1:0] i_dram_data,
	output logic                               o_wr0_valid,
	output ldr_pkg::row_wr_t                   o_wr0,
	output logic                               o_wr1_valid,
	output ldr_pkg::row_wr_t                   o_wr1,
	output logic                               o_done
);
	import ldr_pkg::*;

	localparam int PBW = $clog2(VSIZE);
	localparam int RBW = $clog2(ROWS);
	localparam int WW  = (VSIZE > CSIZE ? VSIZE : CSIZE) * DBW;
	localparam logic [VSIZE:0] ONE_V = 1;

	typedef enum logic {FREE, RUN} state_e;

	state_e                    state;
	logic [SZ_BW-1:0]          size_r;
	logic [DBW-1:0]            padv_r;
	logic                      islast_id_r;
	logic [SZ_BW-1:0]          filled_r;
	logic [LEN_BW-1:0]         handled_r;
	logic [LEN_BW-1:0]         buf_left;
	logic [LEN_BW-1:0]         cmd_left;
	logic [LEN_BW-1:0]         advance;
	logic [LEN_BW-1:0]         row_top;
	logic [SZ_BW-1:0]          filled_nxt;
	logic                      need_dram;
	logic                      take;
	logic                      fill_done;
	logic                      collect;
	logic [VSIZE:0]            ones_adv;
	logic [VSIZE:0]            ones_top;
	logic [VSIZE-1:0]          wmask;
	logic [WW-1:0]             beat_shr;
	logic [WW-1:0]             beat_shl;
	logic [VSIZE-1:0][DBW-1:0] data_w;
	logic [VSIZE-1:0][DBW-1:0] row_buf;
	logic [VSIZE-1:0]          mask_r;
	logic [RBW-1:0]            ptr0;
	logic [RBW-1:0]            ptr1;
	logic                      force_align;

	// ============================================================
	// Handshake and fill accounting
	// ============================================================
	always_comb begin
		buf_left   = LEN_BW'(VSIZE) - LEN_BW'(filled_r[PBW-1:0]);
		cmd_left   = i_cmd.len - handled_r;
		advance    = (cmd_left > buf_left) ? buf_left : cmd_left;
		row_top    = LEN_BW'(filled_r[PBW-1:0]) + advance;
		need_dram  = i_cmd.mode != FILL_PAD;
		take       = state == RUN && i_cmd_rdy && (!need_dram || i_dram_rdy);
		filled_nxt = filled_r + SZ_BW'(advance);
		fill_done  = filled_nxt == size_r;
		// A row goes out when it is full or the block ends inside it
		collect     = take && (cmd_left >= buf_left || fill_done);
		o_cmd_ack   = take && cmd_left <= buf_left;
		o_dram_ack  = o_cmd_ack && need_dram && i_cmd.islast;
		o_alloc_ack = state == FREE && i_alloc_rdy;
		ones_adv = (ONE_V << advance) - 1'b1;
		ones_top = (ONE_V << row_top) - 1'b1;
		wmask    = ones_adv[VSIZE-1:0] << filled_r[PBW-1:0];
	end

	// ============================================================
	// Word alignment
	// ============================================================
	always_comb begin
		beat_shr = WW'(i_dram_data) >> ((int'(i_cmd.addrofs) + int'(handled_r)) * DBW);
		beat_shl = beat_shr << (int'(filled_r[PBW-1:0]) * DBW);
		for (int i = 0; i < VSIZE; i++) begin
			case (i_cmd.mode)
				FILL_COPY:  data_w[i] = beat_shl[i*DBW +: DBW];
				FILL_BCAST: data_w[i] = i_dram_data[i_cmd.addrofs];
				default:    data_w[i] = padv_r;
			endcase
		end
	end

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			state     <= FREE;
			filled_r  <= '0;
			handled_r <= '0;
		end else if (o_alloc_ack) begin
			state     <= RUN;
			filled_r  <= '0;
			handled_r <= '0;
		end else if (take) begin
			handled_r <= o_cmd_ack ? '0 : handled_r + advance;
			if (fill_done) begin
				state    <= FREE;
				filled_r <= '0;
			end else begin
				filled_r <= filled_nxt;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_alloc_ack) begin
			size_r      <= i_alloc.size;
			padv_r      <= i_alloc.padv;
			islast_id_r <= i_alloc.islast_id;
		end
		for (int i = 0; i < VSIZE; i++) begin
			if (take && wmask[i]) begin
				row_buf[i] <= data_w[i];
			end
		end
		if (collect) begin
			mask_r <= ones_top[VSIZE-1:0];
		end
	end

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			o_wr0_valid <= 1'b0;
			o_wr1_valid <= 1'b0;
			o_done      <= 1'b0;
			force_align <= 1'b0;
		end else begin
			o_wr0_valid <= collect && !i_cmd.which;
			o_wr1_valid <= collect && i_cmd.which;
			o_done      <= take && fill_done;
			force_align <= take && fill_done && islast_id_r;
		end
	end

	// ============================================================
	// Ping-pong row pointers
	// ============================================================
	function automatic logic [RBW-1:0] next_ptr(input logic [RBW-1:0] ptr, input logic align);
		logic [RBW-1:0] inc;
		inc = ptr + 1'b1;
		// Land on row 0 of the half opposite the one just written
		if (align) begin
			return {inc[RBW-1] ^ (|inc[RBW-2:0]), {(RBW-1){1'b0}}};
		end
		return inc;
	endfunction

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			ptr0 <= '0;
			ptr1 <= '0;
		end else begin
			if (o_wr0_valid) begin
				ptr0 <= next_ptr(ptr0, force_align);
			end
			if (o_wr1_valid) begin
				ptr1 <= next_ptr(ptr1, force_align);
			end
		end
	end

	assign o_wr0 = '{addr: ptr0, mask: mask_r, data: row_buf};
	assign o_wr1 = '{addr: ptr1, mask: mask_r, data: row_buf};

	ap_dram_ack_rdy: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_dram_ack |-> i_dram_rdy);

endmodule

// ==== src/cmd_gen.sv ====
`timescale 1ns/1ps
// Fill command generator
// Hands the active descriptor to the collector as an allocation, then
// splits the block into per-beat commands that never cross a row

module cmd_gen #(
	parameter int VSIZE = ldr_pkg::VSIZE,
	parameter int CSIZE = ldr_pkg::CSIZE
) (
	input  logic               i_clk,
	input  logic               i_rst,
	input  ldr_pkg::ldr_desc_t i_desc,
	input  logic               i_start,
	output logic               o_alloc_rdy,
	input  logic               i_alloc_ack,
	output ldr_pkg::ldr_desc_t o_alloc,
	output logic               o_cmd_rdy,
	input  logic               i_cmd_ack,
	output ldr_pkg::ldr_cmd_t  o_cmd
);
	import ldr_pkg::*;

	localparam int PBW = $clog2(VSIZE);

	typedef enum logic [1:0] {IDLE, ALLOC, CMD} state_e;

	state_e            state;
	logic [SZ_BW-1:0]  left_r;
	logic [OFS_BW-1:0] beat_pos_r;
	logic [PBW-1:0]    row_pos_r;
	logic [SZ_BW-1:0]  beat_room;
	logic [SZ_BW-1:0]  row_room;
	logic [SZ_BW-1:0]  step;
	logic              beat_end;
	logic              row_end;
	logic              blk_end;

	// Descriptor is held by the register block for the whole block
	assign o_alloc     = i_desc;
	assign o_alloc_rdy = state == ALLOC;
	assign o_cmd_rdy   = state == CMD;

	// Step is bounded by the row, the block and, for copy, the beat
	always_comb begin
		beat_room = SZ_BW'(CSIZE) - SZ_BW'(beat_pos_r);
		row_room  = SZ_BW'(VSIZE) - SZ_BW'(row_pos_r);
		step = row_room;
		if (i_desc.mode == FILL_COPY && beat_room < step) begin
			step = beat_room;
		end
		if (left_r < step) begin
			step = left_r;
		end
		beat_end = step == beat_room;
		row_end  = step == row_room;
		blk_end  = step == left_r;
	end

	always_comb begin
		o_cmd.mode  = i_desc.mode;
		o_cmd.which = i_desc.which;
		o_cmd.len   = LEN_BW'(step);
		case (i_desc.mode)
			FILL_COPY: begin
				o_cmd.addrofs = beat_pos_r;
				o_cmd.islast  = beat_end || blk_end;
			end
			FILL_BCAST: begin
				o_cmd.addrofs = i_desc.ofs;
				o_cmd.islast  = blk_end;
			end
			default: begin
				// Pad never touches a beat
				o_cmd.addrofs = '0;
				o_cmd.islast  = 1'b0;
			end
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			state      <= IDLE;
			left_r     <= '0;
			beat_pos_r <= '0;
			row_pos_r  <= '0;
		end else begin
			case (state)
				IDLE: if (i_start) begin
					left_r     <= i_desc.size;
					beat_pos_r <= i_desc.ofs;
					row_pos_r  <= '0;
					state      <= ALLOC;
				end
				ALLOC: if (i_alloc_ack) begin
					state <= CMD;
				end
				CMD: if (i_cmd_ack) begin
					left_r     <= left_r - step;
					beat_pos_r <= beat_end ? '0 : beat_pos_r + OFS_BW'(step);
					row_pos_r  <= row_end ? '0 : row_pos_r + PBW'(step);
					if (blk_end) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	ap_len_nonzero: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_cmd_rdy |-> o_cmd.len != '0);

endmodule

// ==== src/wb_ldr_regs.sv ====
`timescale 1ns/1ps
// Host register block
// Wishbone classic slave with the block descriptor, start and busy
// control, and a read window onto both local banks

module wb_ldr_regs #(
	parameter int VSIZE = ldr_pkg::VSIZE,
	parameter int ROWS  = ldr_pkg::ROWS
) (
	input  logic                      i_clk,
	input  logic                      i_rst,
	input  logic                      i_wb_cyc,
	input  logic                      i_wb_stb,
	input  logic                      i_wb_we,
	input  logic [ldr_pkg::WB_AW-1:0] i_wb_adr,
	input  logic [ldr_pkg::DBW-1:0]   i_wb_dat,
	output logic [ldr_pkg::DBW-1:0]   o_wb_dat,
	output logic                      o_wb_ack,
	output ldr_pkg::ldr_desc_t        o_desc,
	output logic                      o_start,
	input  logic                      i_done,
	output logic                      o_rd_bank,
	output logic [$clog2(ROWS)-1:0]   o_rd_row,
	output logic [$clog2(VSIZE)-1:0]  o_rd_word,
	input  logic [ldr_pkg::DBW-1:0]   i_rd_data
);
	import ldr_pkg::*;

	localparam int RBW = $clog2(ROWS);
	localparam int WBW = $clog2(VSIZE);

	logic           acc;
	logic           wr;
	logic           is_bank;
	logic [2:0]     reg_sel;
	logic           busy;
	logic [DBW-1:0] rd_mux;

	// Request seen this cycle, ack follows on the next edge
	assign acc     = i_wb_cyc && i_wb_stb && !o_wb_ack;
	assign wr      = acc && i_wb_we;
	assign is_bank = i_wb_adr[WB_AW-1];
	assign reg_sel = i_wb_adr[2:0];

	// Bank window, bank in bit 7, row in 6..3, word in the low bits
	assign o_rd_bank = i_wb_adr[7];
	assign o_rd_row  = i_wb_adr[3 +: RBW];
	assign o_rd_word = i_wb_adr[WBW-1:0];

	assign o_start = wr && !is_bank && reg_sel == 3'd4 && i_wb_dat[0] && !busy;

	always_comb begin
		rd_mux = '0;
		if (is_bank) begin
			rd_mux = i_rd_data;
		end else begin
			case (reg_sel)
				3'd0: rd_mux = DBW'(o_desc.size);
				3'd1: rd_mux = DBW'({o_desc.islast_id, o_desc.which, o_desc.mode});
				3'd2: rd_mux = DBW'(o_desc.ofs);
				3'd3: rd_mux = o_desc.padv;
				3'd4: rd_mux = DBW'(busy);
				default: rd_mux = '0;
			endcase
		end
	end

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			o_wb_ack <= 1'b0;
			busy     <= 1'b0;
		end else begin
			o_wb_ack <= acc;
			if (o_start) begin
				busy <= 1'b1;
			end else if (i_done) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (acc) begin
			o_wb_dat <= rd_mux;
		end
	end

	// Descriptor is frozen while a block is in flight
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			o_desc <= '0;
		end else if (wr && !is_bank && !busy) begin
			case (reg_sel)
				3'd0: o_desc.size <= i_wb_dat[SZ_BW-1:0];
				3'd1: begin
					o_desc.mode      <= fill_mode_e'(i_wb_dat[1:0]);
					o_desc.which     <= i_wb_dat[2];
					o_desc.islast_id <= i_wb_dat[3];
				end
				3'd2: o_desc.ofs  <= i_wb_dat[OFS_BW-1:0];
				3'd3: o_desc.padv <= i_wb_dat;
				default: ;
			endcase
		end
	end

	ap_ack_after_req: assert property (@(posedge i_clk) disable iff (!i_rst)
		$rose(o_wb_ack) |-> $past(i_wb_cyc && i_wb_stb));

endmodule

// ==== src/local_bank.sv ====
`timescale 1ns/1ps
// Local SRAM bank
// Row-wide masked write port and a combinational word read port

module local_bank #(
	parameter int VSIZE = ldr_pkg::VSIZE,
	parameter int ROWS  = ldr_pkg::ROWS
) (
	input  logic                     i_clk,
	input  logic                     i_rst,
	input  logic                     i_wr_valid,
	input  ldr_pkg::row_wr_t         i_wr,
	input  logic [$clog2(ROWS)-1:0]  i_rd_row,
	input  logic [$clog2(VSIZE)-1:0] i_rd_word,
	output logic [ldr_pkg::DBW-1:0]  o_rd_data
);
	import ldr_pkg::*;

	logic [DBW-1:0] mem [ROWS][VSIZE];

	// Words outside the mask keep their old contents
	always_ff @(posedge i_clk) begin
		if (i_wr_valid) begin
			for (int w = 0; w < VSIZE; w++) begin
				if (i_wr.mask[w]) begin
					mem[i_wr.addr][w] <= i_wr.data[w];
				end
			end
		end
	end

	assign o_rd_data = mem[i_rd_row][i_rd_word];

	// Rows always fill from word 0, so any row write covers it
	ap_row_starts_at_zero: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_wr_valid |-> i_wr.mask[0]);

endmodule

// ==== src/ldr_pkg.sv ====
// Tile loader shared definitions
// Sizes, fill modes and the descriptor, command and row write formats
// used by the host registers, the command generator and the collector

package ldr_pkg;

	// Default geometry, overridden per instance from the top level
	localparam int DBW   = 16;
	localparam int VSIZE = 4;
	localparam int CSIZE = 4;
	localparam int ROWS  = 16;
	localparam int SZ_BW = 8;

	localparam int OFS_BW = $clog2(CSIZE);
	localparam int LEN_BW = $clog2(VSIZE + 1);
	localparam int ROW_BW = $clog2(ROWS);

	// Host bus address width, bit 8 selects the bank window
	localparam int WB_AW = 9;

	typedef enum logic [1:0] {
		FILL_COPY  = 2'd0,
		FILL_BCAST = 2'd1,
		FILL_PAD   = 2'd2
	} fill_mode_e;

	typedef struct packed {
		logic [SZ_BW-1:0]  size;
		fill_mode_e        mode;
		logic [OFS_BW-1:0] ofs;
		logic [DBW-1:0]    padv;
		logic              which;
		logic              islast_id;
	} ldr_desc_t;

	typedef struct packed {
		fill_mode_e        mode;
		logic              which;
		logic              islast;
		logic [OFS_BW-1:0] addrofs;
		logic [LEN_BW-1:0] len;
	} ldr_cmd_t;

	// Mask marks the words of the row that the write touches
	typedef struct packed {
		logic [ROW_BW-1:0]          addr;
		logic [VSIZE-1:0]           mask;
		logic [VSIZE-1:0][DBW-1:0]  data;
	} row_wr_t;

endpackage
